// ==== logic/npc_pkg.sv ====
// shared sizes, encodings and records for the single-cycle rv64 core; RV64I subset only, no csr
package npc_pkg;

  localparam int unsigned XLEN        = 64;
  localparam logic [63:0] RESET_PC    = 64'h0;
  localparam int unsigned IMEM_WORDS  = 256;  // 32-bit words, index pc[9:2]
  localparam int unsigned DMEM_DWORDS = 256;  // doublewords, index addr[10:3]
  localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OPIMM  = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_PASSB  // lui
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU,
    BR_JAL,
    BR_JALR
  } br_kind_e;

  typedef struct packed {
    alu_op_e  alu_op;
    logic     a_is_pc;   // operand a is pc, not rs1
    logic     b_is_imm;  // operand b is imm, not rs2
    br_kind_e br_kind;
    logic     rf_wen;
    logic     mem_rd;
    logic     mem_wr;
    logic     link;      // write back pc+4
    logic     halt;
  } ctrl_t;

  // all enables off, also used for unknown encodings
  localparam ctrl_t CTRL_NOP = '{
    alu_op:   ALU_ADD,
    a_is_pc:  1'b0,
    b_is_imm: 1'b0,
    br_kind:  BR_NONE,
    rf_wen:   1'b0,
    mem_rd:   1'b0,
    mem_wr:   1'b0,
    link:     1'b0,
    halt:     1'b0
  };

  // one retired instruction as seen from outside
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [4:0]      rd;
    logic            rf_wen;
    logic [XLEN-1:0] wdata;
  } retire_t;

endpackage

// ==== logic/npc_ifu.sv ====
// pc, instruction memory and halt flag; imem has no reset, load it through the write port
`timescale 1ns/1ps

module npc_ifu import npc_pkg::*; (
  input  logic            i_clk,
  input  logic            i_arst_n,
  input  logic [XLEN-1:0] i_next_pc,
  input  logic            i_halt,
  input  logic            i_imem_we,
  input  logic [7:0]      i_imem_addr,
  input  logic [31:0]     i_imem_wdata,
  output logic [XLEN-1:0] o_pc,
  output logic [31:0]     o_inst,
  output logic            o_halted
);

  logic [XLEN-1:0] pc_q;
  logic            halted_q;
  logic [31:0]     imem [IMEM_WORDS];

  // loader port, open in reset and in run
  always_ff @(posedge i_clk) begin
    if (i_imem_we) begin
      imem[i_imem_addr] <= i_imem_wdata;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q     <= RESET_PC;
      halted_q <= 1'b0;
    end else if (!halted_q) begin
      if (i_halt) begin
        halted_q <= 1'b1;  // pc stays on the ebreak
      end else begin
        pc_q <= i_next_pc;
      end
    end
  end

  assign o_pc     = pc_q;
  assign o_inst   = imem[pc_q[9:2]];  // word index, low bits ignored
  assign o_halted = halted_q;

endmodule

// ==== logic/npc_idu.sv ====
// decoder, immediates and 32x64 register file; unknown encodings decode as a no-op
`timescale 1ns/1ps

module npc_idu import npc_pkg::*; (
  input  logic            i_clk,
  input  logic            i_arst_n,
  input  logic [31:0]     i_inst,
  input  logic            i_wen,
  input  logic [4:0]      i_waddr,
  input  logic [XLEN-1:0] i_wdata,
  output logic [XLEN-1:0] o_rs1,
  output logic [XLEN-1:0] o_rs2,
  output logic [XLEN-1:0] o_imm,
  output logic [4:0]      o_rd,
  output ctrl_t           o_ctrl
);

  logic [XLEN-1:0] rf [32];
  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [4:0]      rs1_idx;
  logic [4:0]      rs2_idx;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  assign opcode  = opcode_e'(i_inst[6:0]);
  assign funct3  = i_inst[14:12];
  assign funct7  = i_inst[31:25];
  assign rs1_idx = i_inst[19:15];
  assign rs2_idx = i_inst[24:20];
  assign o_rd    = i_inst[11:7];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_ctrl = CTRL_NOP;
    o_imm  = imm_i;
    case (opcode)
      OPC_LUI: begin
        o_ctrl.alu_op   = ALU_PASSB;
        o_ctrl.b_is_imm = 1'b1;
        o_ctrl.rf_wen   = 1'b1;
        o_imm           = imm_u;
      end
      OPC_AUIPC: begin
        o_ctrl.a_is_pc  = 1'b1;
        o_ctrl.b_is_imm = 1'b1;
        o_ctrl.rf_wen   = 1'b1;
        o_imm           = imm_u;
      end
      OPC_JAL: begin
        o_ctrl.br_kind = BR_JAL;
        o_ctrl.rf_wen  = 1'b1;
        o_ctrl.link    = 1'b1;
        o_imm          = imm_j;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          o_ctrl.br_kind  = BR_JALR;
          o_ctrl.b_is_imm = 1'b1;  // alu forms rs1+imm
          o_ctrl.rf_wen   = 1'b1;
          o_ctrl.link     = 1'b1;
        end
      end
      OPC_BRANCH: begin
        o_imm = imm_b;
        case (funct3)
          3'b000:  o_ctrl.br_kind = BR_EQ;
          3'b001:  o_ctrl.br_kind = BR_NE;
          3'b100:  o_ctrl.br_kind = BR_LT;
          3'b101:  o_ctrl.br_kind = BR_GE;
          3'b110:  o_ctrl.br_kind = BR_LTU;
          3'b111:  o_ctrl.br_kind = BR_GEU;
          default: o_ctrl.br_kind = BR_NONE;
        endcase
      end
      OPC_LOAD: begin
        if (funct3 == 3'b011) begin  // ld only
          o_ctrl.b_is_imm = 1'b1;
          o_ctrl.rf_wen   = 1'b1;
          o_ctrl.mem_rd   = 1'b1;
        end
      end
      OPC_STORE: begin
        o_imm = imm_s;
        if (funct3 == 3'b011) begin  // sd only
          o_ctrl.b_is_imm = 1'b1;
          o_ctrl.mem_wr   = 1'b1;
        end
      end
      OPC_OPIMM: begin
        o_ctrl.b_is_imm = 1'b1;
        o_ctrl.rf_wen   = 1'b1;
        case (funct3)
          3'b000:  o_ctrl.alu_op = ALU_ADD;
          3'b010:  o_ctrl.alu_op = ALU_SLT;
          3'b100:  o_ctrl.alu_op = ALU_XOR;
          3'b110:  o_ctrl.alu_op = ALU_OR;
          3'b111:  o_ctrl.alu_op = ALU_AND;
          default: o_ctrl = CTRL_NOP;
        endcase
      end
      OPC_OP: begin
        o_ctrl.rf_wen = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: o_ctrl.alu_op = ALU_ADD;
          10'b0100000_000: o_ctrl.alu_op = ALU_SUB;
          10'b0000000_010: o_ctrl.alu_op = ALU_SLT;
          10'b0000000_011: o_ctrl.alu_op = ALU_SLTU;
          10'b0000000_100: o_ctrl.alu_op = ALU_XOR;
          10'b0000000_110: o_ctrl.alu_op = ALU_OR;
          10'b0000000_111: o_ctrl.alu_op = ALU_AND;
          default:         o_ctrl = CTRL_NOP;
        endcase
      end
      OPC_SYSTEM: begin
        o_ctrl.halt = (i_inst == INST_EBREAK);
      end
      default: o_ctrl = CTRL_NOP;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < 32; i++) begin
        rf[i] <= '0;
      end
    end else if (i_wen && i_waddr != 5'd0) begin
      rf[i_waddr] <= i_wdata;
    end
  end

  assign o_rs1 = (rs1_idx == 5'd0) ? '0 : rf[rs1_idx];
  assign o_rs2 = (rs2_idx == 5'd0) ? '0 : rf[rs2_idx];

endmodule

// ==== logic/npc_exu.sv ====
// alu, branch decision and next pc; purely combinational
`timescale 1ns/1ps

module npc_exu import npc_pkg::*; (
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_rs1,
  input  logic [XLEN-1:0] i_rs2,
  input  logic [XLEN-1:0] i_imm,
  input  ctrl_t           i_ctrl,
  output logic [XLEN-1:0] o_result,
  output logic [XLEN-1:0] o_next_pc
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic            eq;
  logic            lt;
  logic            ltu;
  logic            taken;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] br_target;

  assign op_a = i_ctrl.a_is_pc  ? i_pc  : i_rs1;
  assign op_b = i_ctrl.b_is_imm ? i_imm : i_rs2;

  // compares shared by slt and branches, branches see rs1/rs2 here
  assign eq  = (op_a == op_b);
  assign lt  = ($signed(op_a) < $signed(op_b));
  assign ltu = (op_a < op_b);

  always_comb begin
    case (i_ctrl.alu_op)
      ALU_ADD:   o_result = op_a + op_b;
      ALU_SUB:   o_result = op_a - op_b;
      ALU_SLT:   o_result = {{(XLEN-1){1'b0}}, lt};
      ALU_SLTU:  o_result = {{(XLEN-1){1'b0}}, ltu};
      ALU_XOR:   o_result = op_a ^ op_b;
      ALU_OR:    o_result = op_a | op_b;
      ALU_AND:   o_result = op_a & op_b;
      ALU_PASSB: o_result = op_b;
      default:   o_result = op_a + op_b;
    endcase
  end

  always_comb begin
    case (i_ctrl.br_kind)
      BR_EQ:   taken = eq;
      BR_NE:   taken = !eq;
      BR_LT:   taken = lt;
      BR_GE:   taken = !lt;
      BR_LTU:  taken = ltu;
      BR_GEU:  taken = !ltu;
      BR_JAL:  taken = 1'b1;
      default: taken = 1'b0;  // jalr handled below
    endcase
  end

  assign pc_plus4  = i_pc + 64'd4;
  assign br_target = i_pc + i_imm;

  always_comb begin
    if (i_ctrl.br_kind == BR_JALR) begin
      o_next_pc = {o_result[XLEN-1:1], 1'b0};  // rs1+imm, bit 0 cleared
    end else if (taken) begin
      o_next_pc = br_target;
    end else begin
      o_next_pc = pc_plus4;
    end
  end

endmodule

// ==== logic/npc_lsu.sv ====
// doubleword data memory and write-back select; ld/sd only, address bits 2:0 ignored, no reset
`timescale 1ns/1ps

module npc_lsu import npc_pkg::*; (
  input  logic            i_clk,
  input  logic [XLEN-1:0] i_addr,
  input  logic [XLEN-1:0] i_wdata,
  input  logic [XLEN-1:0] i_pc,
  input  ctrl_t           i_ctrl,
  output logic [XLEN-1:0] o_rf_wdata
);

  logic [XLEN-1:0] dmem [DMEM_DWORDS];
  logic [XLEN-1:0] load_data;

  always_ff @(posedge i_clk) begin
    if (i_ctrl.mem_wr) begin
      dmem[i_addr[10:3]] <= i_wdata;
    end
  end

  assign load_data = dmem[i_addr[10:3]];  // sees earlier stores only

  always_comb begin
    if (i_ctrl.mem_rd) begin
      o_rf_wdata = load_data;
    end else if (i_ctrl.link) begin
      o_rf_wdata = i_pc + 64'd4;
    end else begin
      o_rf_wdata = i_addr;  // alu result
    end
  end

endmodule

// ==== logic/npc_core.sv ====
// single-cycle rv64 core top; first instruction retires one edge after reset release
`timescale 1ns/1ps

module npc_core import npc_pkg::*; (
  input  logic        i_clk,
  input  logic        i_arst_n,
  input  logic        i_imem_we,
  input  logic [7:0]  i_imem_addr,
  input  logic [31:0] i_imem_wdata,
  output retire_t     o_retire,
  output logic        o_halted
);

  logic [XLEN-1:0] pc;
  logic [31:0]     inst;
  logic            halted;
  logic            started;
  logic            live;
  logic [XLEN-1:0] rs1;
  logic [XLEN-1:0] rs2;
  logic [XLEN-1:0] imm;
  logic [4:0]      rd;
  ctrl_t           ctrl;
  ctrl_t           ctrl_live;
  logic [XLEN-1:0] result;
  logic [XLEN-1:0] exu_next_pc;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] rf_wdata;

  // goes high at the first edge after release
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      started <= 1'b0;
    end else begin
      started <= 1'b1;
    end
  end

  assign live    = started && !halted;
  assign next_pc = started ? exu_next_pc : pc;  // hold RESET_PC for one edge

  // no commits outside a live cycle
  always_comb begin
    ctrl_live = ctrl;
    if (!live) begin
      ctrl_live.rf_wen = 1'b0;
      ctrl_live.mem_wr = 1'b0;
      ctrl_live.halt   = 1'b0;
    end
  end

  npc_ifu u_ifu (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_next_pc   (next_pc),
    .i_halt      (ctrl_live.halt),
    .i_imem_we   (i_imem_we),
    .i_imem_addr (i_imem_addr),
    .i_imem_wdata(i_imem_wdata),
    .o_pc        (pc),
    .o_inst      (inst),
    .o_halted    (halted)
  );

  npc_idu u_idu (
    .i_clk   (i_clk),
    .i_arst_n(i_arst_n),
    .i_inst  (inst),
    .i_wen   (ctrl_live.rf_wen),
    .i_waddr (rd),
    .i_wdata (rf_wdata),
    .o_rs1   (rs1),
    .o_rs2   (rs2),
    .o_imm   (imm),
    .o_rd    (rd),
    .o_ctrl  (ctrl)
  );

  npc_exu u_exu (
    .i_pc     (pc),
    .i_rs1    (rs1),
    .i_rs2    (rs2),
    .i_imm    (imm),
    .i_ctrl   (ctrl),
    .o_result (result),
    .o_next_pc(exu_next_pc)
  );

  npc_lsu u_lsu (
    .i_clk     (i_clk),
    .i_addr    (result),
    .i_wdata   (rs2),
    .i_pc      (pc),
    .i_ctrl    (ctrl_live),
    .o_rf_wdata(rf_wdata)
  );

  // write-back is plain wiring, retire record mirrors it
  assign o_retire.valid  = live;
  assign o_retire.pc     = pc;
  assign o_retire.rd     = rd;
  assign o_retire.rf_wen = ctrl_live.rf_wen;
  assign o_retire.wdata  = rf_wdata;
  assign o_halted        = halted;

endmodule

// ==== verification/npc_core_tb.sv ====
// directed tests for npc_core; programs are hand-encoded, end with EBREAK, and dmem is never cleared
`timescale 1ns/1ps

module npc_core_tb import npc_pkg::*; ();

  localparam int CLK_PERIOD      = 20;
  localparam int N_TESTS         = 6;
  localparam int CYCLES_PER_TEST = 200;
  localparam int RUN_LIMIT       = 150;  // cycles from reset release to halt

  logic        clk;
  logic        arst_n;
  logic        imem_we;
  logic [7:0]  imem_addr;
  logic [31:0] imem_wdata;
  retire_t     retire;
  logic        halted;

  logic [31:0] prog [$];
  retire_t     exp_q [$];
  retire_t     got_q [$];
  logic        halt_seen;
  int          errors;
  int          tests;
  int          failed_tests;
  int          errors_before;

  npc_core u_dut (
    .i_clk       (clk),
    .i_arst_n    (arst_n),
    .i_imem_we   (imem_we),
    .i_imem_addr (imem_addr),
    .i_imem_wdata(imem_wdata),
    .o_retire    (retire),
    .o_halted    (halted)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [63:0] sx12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic [63:0] u_val(input logic [19:0] v);
    return {{32{v[19]}}, v, 12'h000};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  // sd only
  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // rv64 branch conditions by funct3
  function automatic logic br_taken(input logic [2:0] f3, input logic [63:0] a,
                                    input logic [63:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [63:0] here();
    return 64'(prog.size()) * 64'd4;  // address of the next word placed
  endfunction

  // places a word that must retire with rd taken from the encoding
  task automatic put(input logic [31:0] inst, input logic wen, input logic [63:0] wdata);
    retire_t r;
    r.valid  = 1'b1;
    r.pc     = here();
    r.rd     = inst[11:7];
    r.rf_wen = wen;
    r.wdata  = wdata;
    exp_q.push_back(r);
    prog.push_back(inst);
  endtask

  task automatic put_dead(input logic [31:0] inst);
    prog.push_back(inst);  // skipped and never retires
  endtask

  task automatic begin_test();
    prog.delete();
    exp_q.delete();
    errors_before = errors;
  endtask

  // load under reset, release, then collect retires until halt
  task automatic run_program();
    int cyc;
    @(posedge clk);
    #2;
    arst_n = 1'b0;
    foreach (prog[i]) begin
      imem_we    = 1'b1;
      imem_addr  = 8'(i);
      imem_wdata = prog[i];
      @(posedge clk);
      #2;
    end
    imem_we = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    arst_n = 1'b1;
    got_q.delete();
    halt_seen = 1'b0;
    cyc = 0;
    while (!halt_seen && cyc < RUN_LIMIT) begin
      @(negedge clk);
      if (halted) begin
        halt_seen = 1'b1;
      end else if (retire.valid) begin
        got_q.push_back(retire);
      end
      cyc++;
    end
  endtask

  task automatic value_error(input string name, input int idx, input logic [63:0] got_v,
                             input logic [63:0] exp_v);
    $display("ERR o_retire.%s #%0d got 0x%h expected 0x%h", name, idx, got_v, exp_v);
    errors++;
  endtask

  // rd and wdata only matter for a register write
  task automatic check_retire(input retire_t got_r, input retire_t exp_r, input int idx);
    if (got_r.pc !== exp_r.pc) value_error("pc", idx, got_r.pc, exp_r.pc);
    if (got_r.rf_wen !== exp_r.rf_wen) begin
      value_error("rf_wen", idx, 64'(got_r.rf_wen), 64'(exp_r.rf_wen));
    end
    if (exp_r.rf_wen) begin
      if (got_r.rd !== exp_r.rd) value_error("rd", idx, 64'(got_r.rd), 64'(exp_r.rd));
      if (got_r.wdata !== exp_r.wdata) value_error("wdata", idx, got_r.wdata, exp_r.wdata);
    end
  endtask

  task automatic check_halt(input int got_n, input int exp_n, input logic seen);
    if (!seen) begin
      $display("halt never came, %0d instructions retired", got_n);
      errors++;
    end else if (got_n < exp_n) begin
      $display("halt came early after %0d retires, expected %0d", got_n, exp_n);
      errors++;
    end else if (got_n > exp_n) begin
      $display("halt came late after %0d retires, expected %0d", got_n, exp_n);
      errors++;
    end
  endtask

  task automatic check_held(input retire_t r, input logic h, input int cyc);
    if (h !== 1'b1) begin
      $display("o_halted dropped %0d cycles after EBREAK", cyc);
      errors++;
    end
    if (r.valid !== 1'b0) begin
      $display("a retire showed up %0d cycles after EBREAK at pc 0x%h", cyc, r.pc);
      errors++;
    end
  endtask

  task automatic compare_results();
    int n;
    check_halt(got_q.size(), exp_q.size(), halt_seen);
    n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
    for (int i = 0; i < n; i++) check_retire(got_q[i], exp_q[i], i);
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors > errors_before) begin
      failed_tests++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic imm_arith();
    logic [11:0] imm [6];
    logic [63:0] x1;
    foreach (imm[i]) imm[i] = 12'($urandom);
    begin_test();
    x1 = sx12(imm[0]);
    put(enc_i(imm[0], 5'd0, 3'b000, 5'd1, OPC_OPIMM), 1'b1, x1);
    put(enc_i(imm[1], 5'd1, 3'b010, 5'd2, OPC_OPIMM), 1'b1,
        ($signed(x1) < $signed(sx12(imm[1]))) ? 64'd1 : 64'd0);
    put(enc_i(imm[2], 5'd1, 3'b100, 5'd3, OPC_OPIMM), 1'b1, x1 ^ sx12(imm[2]));
    put(enc_i(imm[3], 5'd1, 3'b110, 5'd4, OPC_OPIMM), 1'b1, x1 | sx12(imm[3]));
    put(enc_i(imm[4], 5'd1, 3'b111, 5'd5, OPC_OPIMM), 1'b1, x1 & sx12(imm[4]));
    put(enc_i(imm[5], 5'd1, 3'b000, 5'd0, OPC_OPIMM), 1'b1, x1 + sx12(imm[5]));  // to x0
    put(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd6), 1'b1, 64'd0);
    put(INST_EBREAK, 1'b0, 64'd0);
    run_program();
    compare_results();
    finish_test("arithmetic immediates");
  endtask

  task automatic reg_arith();
    logic [63:0] a;
    logic [63:0] b;
    begin_test();
    a = u_val(20'h80000) + sx12(12'h123);  // negative
    b = u_val(20'h12345) + sx12(12'hfff);
    put(enc_u(20'h80000, 5'd1, OPC_LUI), 1'b1, u_val(20'h80000));
    put(enc_i(12'h123, 5'd1, 3'b000, 5'd1, OPC_OPIMM), 1'b1, a);
    put(enc_u(20'h12345, 5'd2, OPC_LUI), 1'b1, u_val(20'h12345));
    put(enc_i(12'hfff, 5'd2, 3'b000, 5'd2, OPC_OPIMM), 1'b1, b);
    put(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1, a + b);
    put(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 1'b1, a - b);
    put(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd5), 1'b1, 64'd1);  // signed a < b
    put(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd6), 1'b1, 64'd0);  // a is huge unsigned
    put(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd10), 1'b1, 64'd0);
    put(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd11), 1'b1, 64'd1);
    put(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), 1'b1, a ^ b);
    put(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd8), 1'b1, a | b);
    put(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd9), 1'b1, a & b);
    put(INST_EBREAK, 1'b0, 64'd0);
    run_program();
    compare_results();
    finish_test("register-register alu");
  endtask

  task automatic branch_paths();
    logic [2:0]  f3 [6];
    logic [4:0]  ra [3];
    logic [4:0]  rb [3];
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] cnt;
    logic [31:0] bump;
    f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    ra = '{5'd1, 5'd2, 5'd1};
    rb = '{5'd2, 5'd1, 5'd1};
    a = sx12(12'hffb);
    b = 64'd3;
    cnt = 64'd0;
    bump = enc_i(12'h001, 5'd7, 3'b000, 5'd7, OPC_OPIMM);  // x7 counts fall-throughs
    begin_test();
    put(enc_i(12'hffb, 5'd0, 3'b000, 5'd1, OPC_OPIMM), 1'b1, a);
    put(enc_i(12'h003, 5'd0, 3'b000, 5'd2, OPC_OPIMM), 1'b1, b);
    for (int k = 0; k < 6; k++) begin
      for (int p = 0; p < 3; p++) begin
        put(enc_b(13'd8, rb[p], ra[p], f3[k]), 1'b0, 64'd0);
        if (br_taken(f3[k], (ra[p] == 5'd1) ? a : b, (rb[p] == 5'd1) ? a : b)) begin
          put_dead(bump);
        end else begin
          cnt = cnt + 64'd1;
          put(bump, 1'b1, cnt);
        end
      end
    end
    put(INST_EBREAK, 1'b0, 64'd0);
    run_program();
    compare_results();
    finish_test("branches");
  endtask

  task automatic jump_links();
    logic [63:0] tgt;
    logic [31:0] dead;
    dead = enc_i(12'h7ff, 5'd0, 3'b000, 5'd7, OPC_OPIMM);
    begin_test();
    put(enc_i(12'h001, 5'd0, 3'b000, 5'd5, OPC_OPIMM), 1'b1, 64'd1);
    put(enc_u(20'hfffff, 5'd1, OPC_AUIPC), 1'b1, here() + u_val(20'hfffff));
    tgt = here() + 64'd12;
    put(enc_j(21'd12, 5'd2), 1'b1, here() + 64'd4);
    while (here() < tgt) put_dead(dead);
    put(enc_i(12'd40, 5'd0, 3'b000, 5'd3, OPC_OPIMM), 1'b1, 64'd40);
    tgt = (64'd40 + 64'd5) & ~64'd1;  // odd sum loses bit 0
    put(enc_i(12'd5, 5'd3, 3'b000, 5'd4, OPC_JALR), 1'b1, here() + 64'd4);
    while (here() < tgt) put_dead(dead);
    tgt = here() + 64'd8;
    put(enc_j(21'd8, 5'd0), 1'b1, here() + 64'd4);  // link to x0 discarded
    while (here() < tgt) put_dead(dead);
    put(enc_u(20'h00002, 5'd6, OPC_AUIPC), 1'b1, here() + 64'h2000);
    put(INST_EBREAK, 1'b0, 64'd0);
    run_program();
    compare_results();
    finish_test("jumps and pc-relative");
  endtask

  task automatic mem_roundtrip();
    logic [63:0] m2;
    logic [63:0] m3;
    m2 = sx12(12'hff9);
    m3 = u_val(20'h7abcd);
    begin_test();
    put(enc_i(12'h100, 5'd0, 3'b000, 5'd1, OPC_OPIMM), 1'b1, 64'h100);
    put(enc_i(12'hff9, 5'd0, 3'b000, 5'd2, OPC_OPIMM), 1'b1, m2);
    put(enc_u(20'h7abcd, 5'd3, OPC_LUI), 1'b1, m3);
    put(enc_s(12'h000, 5'd2, 5'd1), 1'b0, 64'd0);
    put(enc_s(12'h008, 5'd3, 5'd1), 1'b0, 64'd0);
    put(enc_s(12'hff0, 5'd2, 5'd1), 1'b0, 64'd0);  // 0x100 - 16
    put(enc_i(12'h000, 5'd1, 3'b011, 5'd4, OPC_LOAD), 1'b1, m2);
    put(enc_i(12'h008, 5'd1, 3'b011, 5'd5, OPC_LOAD), 1'b1, m3);
    put(enc_s(12'h000, 5'd3, 5'd1), 1'b0, 64'd0);  // overwrite
    put(enc_i(12'h000, 5'd1, 3'b011, 5'd6, OPC_LOAD), 1'b1, m3);
    put(enc_i(12'hff0, 5'd1, 3'b011, 5'd7, OPC_LOAD), 1'b1, m2);
    put(INST_EBREAK, 1'b0, 64'd0);
    run_program();
    compare_results();
    finish_test("memory");
  endtask

  task automatic halt_and_reset();
    begin_test();
    put(enc_i(12'h005, 5'd0, 3'b000, 5'd1, OPC_OPIMM), 1'b1, 64'd5);
    put(enc_i(12'h009, 5'd0, 3'b000, 5'd2, OPC_OPIMM), 1'b1, 64'd9);
    put(INST_EBREAK, 1'b0, 64'd0);
    run_program();
    compare_results();
    for (int c = 1; c <= 10; c++) begin
      @(negedge clk);
      check_held(retire, halted, c);
    end
    // registers must come back cleared on the second run
    prog.delete();
    exp_q.delete();
    put(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1, 64'd0);
    put(enc_r(7'h00, 5'd0, 5'd1, 3'b000, 5'd4), 1'b1, 64'd0);
    put(enc_r(7'h00, 5'd0, 5'd2, 3'b000, 5'd5), 1'b1, 64'd0);
    put(INST_EBREAK, 1'b0, 64'd0);
    run_program();
    compare_results();
    finish_test("halt and reset");
  endtask

  initial begin
    #(CYCLES_PER_TEST * N_TESTS * CLK_PERIOD);
    $display("watchdog: run still going after %0d cycles", CYCLES_PER_TEST * N_TESTS);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(90));
    clk          = 1'b0;
    arst_n       = 1'b0;
    imem_we      = 1'b0;
    imem_addr    = '0;
    imem_wdata   = '0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    imm_arith();
    reg_arith();
    branch_paths();
    jump_links();
    mem_roundtrip();
    halt_and_reset();
    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== npc_core.f ====
logic/npc_pkg.sv
logic/npc_ifu.sv
logic/npc_idu.sv
logic/npc_exu.sv
logic/npc_lsu.sv
logic/npc_core.sv
verification/npc_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds with verilator, runs, and decides pass or fail from the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module npc_core_tb -f npc_core.f -o npc_core_sim \
  && ./obj_dir/npc_core_sim | tee sim.log \
  && grep -q "ALL CHECKS PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
